//--- design/game_pkg.sv
// Game types, arena bounds and spawn table shared by every game-logic module
`default_nettype none

package game_pkg;

    typedef logic [9:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    typedef enum logic [1:0] {DIR_UP, DIR_DOWN, DIR_LEFT, DIR_RIGHT} dir_e;

    typedef enum logic [1:0] {PH_IDLE, PH_PLAY, PH_LEVEL_DONE, PH_GAME_OVER} phase_e;

    // ------------------------------
    // Arena and movement
    localparam coord_t ARENA_MIN    = 10'd16;   // Same bounds on x and y
    localparam coord_t ARENA_MAX    = 10'd463;
    localparam pos_t   SHOOTER_START = '{x: 10'd240, y: 10'd240};
    localparam coord_t SHOOTER_STEP = 10'd8;
    localparam coord_t BULLET_STEP  = 10'd16;
    localparam coord_t ZOMBIE_STEP  = 10'd2;
    localparam coord_t HIT_SIZE     = 10'd8;    // Half-width of every box
    localparam logic [2:0] START_HEALTH = 3'd3;

    // ------------------------------
    // Zombie spawning, one corner each
    localparam pos_t SPAWN_POS [4] = '{
        '{x: 10'd32,  y: 10'd32},
        '{x: 10'd448, y: 10'd32},
        '{x: 10'd32,  y: 10'd448},
        '{x: 10'd448, y: 10'd448}
    };
    localparam logic [7:0] SPAWN_DELAY = 8'd4;  // Ticks

endpackage

`default_nettype wire

//--- design/bus_pkg.sv
// Wishbone request and response types, register map and host command opcodes
`default_nettype none

package bus_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;   // Word address
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [3:0] {
        REG_CTRL, REG_CMD, REG_STATUS, REG_SCORE, REG_SHOOTER, REG_BULLET, REG_ALIVE,
        REG_ZOMBIE0, REG_ZOMBIE1, REG_ZOMBIE2, REG_ZOMBIE3
    } reg_e;

    typedef enum logic [2:0] {
        CMD_NONE, CMD_MOVE_UP, CMD_MOVE_DOWN, CMD_MOVE_LEFT, CMD_MOVE_RIGHT, CMD_FIRE
    } cmd_e;

endpackage

`default_nettype wire

//--- design/frame_timer.sv
// Frame timer, divides the core clock down to the one-cycle game tick
`default_nettype none

module frame_timer #(
    parameter int FRAME_CYCLES = 1000
) (
    input  wire  Clk,
    input  wire  rst_n,
    output logic frame_tick
);
    localparam int CW = $clog2(FRAME_CYCLES + 1);

    logic [CW-1:0] count;

    assign frame_tick = (count == '0);

    always_ff @(posedge Clk) begin
        if (!rst_n || frame_tick) begin
            count <= CW'(FRAME_CYCLES - 1);     // Reload
        end else begin
            count <= count - 1'b1;
        end
    end

    // Tick spacing seen by every consumer
    a_tick_single: assert property (@(posedge Clk) disable iff (!rst_n)
        frame_tick |=> !frame_tick);

endmodule

`default_nettype wire

//--- design/game_fsm.sv
// Game phase FSM, keeps level, health and score and signals each new level
`default_nettype none

module game_fsm #(
    parameter int N_ZOMBIES = 3
) (
    input  wire                    Clk,
    input  wire                    rst_n,
    input  wire                    frame_tick,
    input  wire                    start,
    input  wire  [N_ZOMBIES-1:0]   zombie_alive,
    input  wire  [N_ZOMBIES-1:0]   kill_hit,
    input  wire  [N_ZOMBIES-1:0]   contact_hit,
    output game_pkg::phase_e       phase,
    output logic [3:0]             level,
    output logic [2:0]             health,
    output logic [7:0]             score,
    output logic                   new_level
);
    logic fresh;    // No full tick played yet in this level

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            phase     <= game_pkg::PH_IDLE;
            level     <= '0;
            health    <= '0;
            score     <= '0;
            new_level <= 1'b0;
            fresh     <= 1'b0;
        end else begin
            new_level <= 1'b0;
            case (phase)
                game_pkg::PH_IDLE, game_pkg::PH_GAME_OVER: begin
                    if (start) begin
                        phase     <= game_pkg::PH_PLAY;
                        level     <= 4'd1;
                        health    <= game_pkg::START_HEALTH;
                        score     <= '0;
                        new_level <= 1'b1;
                        fresh     <= 1'b1;
                    end
                end
                game_pkg::PH_PLAY: begin
                    // Actors are still respawning while new_level is high
                    if (frame_tick && !new_level) begin
                        fresh <= 1'b0;
                        if (|kill_hit) score <= score + 1'b1;
                        if (|contact_hit) health <= health - 1'b1;
                        if (|contact_hit && health == 3'd1) begin
                            phase <= game_pkg::PH_GAME_OVER;
                        end else if (!fresh && zombie_alive == '0) begin
                            phase <= game_pkg::PH_LEVEL_DONE;
                        end
                    end
                end
                default: begin      // Level done lasts one tick
                    if (frame_tick) begin
                        phase     <= game_pkg::PH_PLAY;
                        level     <= level + 1'b1;
                        new_level <= 1'b1;
                        fresh     <= 1'b1;
                    end
                end
            endcase
        end
    end

    a_score_frozen: assert property (@(posedge Clk) disable iff (!rst_n)
        (phase != game_pkg::PH_PLAY && !start) |=> $stable(score));

endmodule

`default_nettype wire

//--- design/shooter_ctrl.sv
// Shooter and bullet mover, consumes one host command per tick in play
`default_nettype none

module shooter_ctrl (
    input  wire                     Clk,
    input  wire                     rst_n,
    input  wire                     frame_tick,
    input  wire game_pkg::phase_e   phase,
    input  wire bus_pkg::cmd_e      cmd,
    output logic                    cmd_taken,
    input  wire                     bullet_stop,
    input  wire                     new_level,
    output game_pkg::pos_t          shooter_pos,
    output game_pkg::pos_t          bullet_pos,
    output logic                    bullet_live
);
    logic              step;
    game_pkg::dir_e    facing;
    game_pkg::dir_e    bullet_dir;
    game_pkg::pos_t    shooter_next;
    game_pkg::pos_t    bullet_next;
    logic              bullet_exit;

    assign step      = frame_tick && (phase == game_pkg::PH_PLAY) && !new_level;
    assign cmd_taken = step && (cmd != bus_pkg::CMD_NONE);

    // ------------------------------
    // Clamped shooter move
    always_comb begin
        shooter_next = shooter_pos;
        case (cmd)
            bus_pkg::CMD_MOVE_UP:
                shooter_next.y = (shooter_pos.y < game_pkg::ARENA_MIN + game_pkg::SHOOTER_STEP)
                    ? game_pkg::ARENA_MIN : shooter_pos.y - game_pkg::SHOOTER_STEP;
            bus_pkg::CMD_MOVE_DOWN:
                shooter_next.y = (shooter_pos.y > game_pkg::ARENA_MAX - game_pkg::SHOOTER_STEP)
                    ? game_pkg::ARENA_MAX : shooter_pos.y + game_pkg::SHOOTER_STEP;
            bus_pkg::CMD_MOVE_LEFT:
                shooter_next.x = (shooter_pos.x < game_pkg::ARENA_MIN + game_pkg::SHOOTER_STEP)
                    ? game_pkg::ARENA_MIN : shooter_pos.x - game_pkg::SHOOTER_STEP;
            bus_pkg::CMD_MOVE_RIGHT:
                shooter_next.x = (shooter_pos.x > game_pkg::ARENA_MAX - game_pkg::SHOOTER_STEP)
                    ? game_pkg::ARENA_MAX : shooter_pos.x + game_pkg::SHOOTER_STEP;
            default: ;
        endcase
    end

    // Bullet step, and whether that step would leave the arena
    always_comb begin
        bullet_next = bullet_pos;
        case (bullet_dir)
            game_pkg::DIR_UP: begin
                bullet_exit   = bullet_pos.y < game_pkg::ARENA_MIN + game_pkg::BULLET_STEP;
                bullet_next.y = bullet_pos.y - game_pkg::BULLET_STEP;
            end
            game_pkg::DIR_DOWN: begin
                bullet_exit   = bullet_pos.y > game_pkg::ARENA_MAX - game_pkg::BULLET_STEP;
                bullet_next.y = bullet_pos.y + game_pkg::BULLET_STEP;
            end
            game_pkg::DIR_LEFT: begin
                bullet_exit   = bullet_pos.x < game_pkg::ARENA_MIN + game_pkg::BULLET_STEP;
                bullet_next.x = bullet_pos.x - game_pkg::BULLET_STEP;
            end
            default: begin
                bullet_exit   = bullet_pos.x > game_pkg::ARENA_MAX - game_pkg::BULLET_STEP;
                bullet_next.x = bullet_pos.x + game_pkg::BULLET_STEP;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            shooter_pos <= game_pkg::SHOOTER_START;
            facing      <= game_pkg::DIR_UP;
            bullet_live <= 1'b0;
            bullet_pos  <= game_pkg::SHOOTER_START;
            bullet_dir  <= game_pkg::DIR_UP;
        end else if (new_level) begin
            shooter_pos <= game_pkg::SHOOTER_START;
            bullet_live <= 1'b0;
        end else if (step) begin
            shooter_pos <= shooter_next;
            case (cmd)
                bus_pkg::CMD_MOVE_UP:    facing <= game_pkg::DIR_UP;
                bus_pkg::CMD_MOVE_DOWN:  facing <= game_pkg::DIR_DOWN;
                bus_pkg::CMD_MOVE_LEFT:  facing <= game_pkg::DIR_LEFT;
                bus_pkg::CMD_MOVE_RIGHT: facing <= game_pkg::DIR_RIGHT;
                default: ;
            endcase
            if (bullet_live) begin
                if (bullet_stop || bullet_exit) bullet_live <= 1'b0;
                else bullet_pos <= bullet_next;
            end else if (cmd == bus_pkg::CMD_FIRE) begin  // Fire while live is dropped
                bullet_live <= 1'b1;
                bullet_pos  <= shooter_pos;
                bullet_dir  <= facing;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/zombie_unit.sv
// One zombie, waits out its spawn delay and then steps toward the shooter each tick
`default_nettype none

module zombie_unit #(
    parameter int ZOMBIE_ID = 0
) (
    input  wire                     Clk,
    input  wire                     rst_n,
    input  wire                     frame_tick,
    input  wire game_pkg::phase_e   phase,
    input  wire                     new_level,
    input  wire game_pkg::pos_t     shooter_pos,
    input  wire                     killed,
    input  wire                     contact,
    output game_pkg::pos_t          zombie_pos,
    output logic                    alive
);
    localparam game_pkg::pos_t SPAWN = game_pkg::SPAWN_POS[ZOMBIE_ID];

    logic [7:0] delay;

    // One axis step that never passes the target
    function automatic game_pkg::coord_t chase_axis(input game_pkg::coord_t cur,
                                                    input game_pkg::coord_t tgt);
        if (cur < tgt) return (tgt - cur > game_pkg::ZOMBIE_STEP) ?
            cur + game_pkg::ZOMBIE_STEP : tgt;
        if (cur > tgt) return (cur - tgt > game_pkg::ZOMBIE_STEP) ?
            cur - game_pkg::ZOMBIE_STEP : tgt;
        return cur;
    endfunction

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            zombie_pos <= SPAWN;
            alive      <= 1'b0;
            delay      <= game_pkg::SPAWN_DELAY;
        end else if (new_level) begin
            zombie_pos <= SPAWN;
            alive      <= 1'b1;
            delay      <= game_pkg::SPAWN_DELAY;
        end else if (frame_tick && phase == game_pkg::PH_PLAY && alive) begin
            if (killed) begin
                alive <= 1'b0;
            end else if (contact) begin     // Bounce back to spawn
                zombie_pos <= SPAWN;
                delay      <= game_pkg::SPAWN_DELAY;
            end else if (delay != '0) begin
                delay <= delay - 1'b1;
            end else begin
                zombie_pos.x <= chase_axis(zombie_pos.x, shooter_pos.x);
                zombie_pos.y <= chase_axis(zombie_pos.y, shooter_pos.y);
            end
        end
    end

    a_in_arena: assert property (@(posedge Clk) disable iff (!rst_n)
        zombie_pos.x inside {[game_pkg::ARENA_MIN:game_pkg::ARENA_MAX]} &&
        zombie_pos.y inside {[game_pkg::ARENA_MIN:game_pkg::ARENA_MAX]});

endmodule

`default_nettype wire

//--- design/hit_detect.sv
// Box-overlap hit tests between the bullet, each zombie and the shooter
`default_nettype none

module hit_detect #(
    parameter int N_ZOMBIES = 3
) (
    input  wire game_pkg::pos_t     bullet_pos,
    input  wire                     bullet_live,
    input  wire game_pkg::pos_t     zombie_pos [N_ZOMBIES],
    input  wire [N_ZOMBIES-1:0]     zombie_alive,
    input  wire game_pkg::pos_t     shooter_pos,
    output logic [N_ZOMBIES-1:0]    kill_hit,
    output logic [N_ZOMBIES-1:0]    contact_hit,
    output logic                    bullet_stop
);
    function automatic logic overlap(input game_pkg::pos_t a, input game_pkg::pos_t b);
        game_pkg::coord_t dx;
        game_pkg::coord_t dy;
        dx = (a.x > b.x) ? a.x - b.x : b.x - a.x;
        dy = (a.y > b.y) ? a.y - b.y : b.y - a.y;
        return (dx < 2 * game_pkg::HIT_SIZE) && (dy < 2 * game_pkg::HIT_SIZE);
    endfunction

    always_comb begin
        kill_hit = '0;
        for (int i = 0; i < N_ZOMBIES; i++) begin
            contact_hit[i] = zombie_alive[i] && overlap(zombie_pos[i], shooter_pos);
            // Lowest-numbered zombie takes the bullet
            if (bullet_live && zombie_alive[i] && overlap(zombie_pos[i], bullet_pos) &&
                kill_hit == '0) kill_hit[i] = 1'b1;
        end
    end

    assign bullet_stop = |kill_hit;

endmodule

`default_nettype wire

//--- design/wb_regs.sv
// Wishbone classic slave for the host, takes commands and returns game state
`default_nettype none

module wb_regs #(
    parameter int N_ZOMBIES = 3
) (
    input  wire                     Clk,
    input  wire                     rst_n,
    input  wire bus_pkg::wb_req_t   bus_req,
    output bus_pkg::wb_rsp_t        bus_rsp,
    input  wire game_pkg::phase_e   phase,
    input  wire [3:0]               level,
    input  wire [2:0]               health,
    input  wire [7:0]               score,
    input  wire game_pkg::pos_t     shooter_pos,
    input  wire game_pkg::pos_t     bullet_pos,
    input  wire                     bullet_live,
    input  wire game_pkg::pos_t     zombie_pos [N_ZOMBIES],
    input  wire [N_ZOMBIES-1:0]     zombie_alive,
    input  wire                     cmd_taken,
    output bus_pkg::cmd_e           cmd,
    output logic                    start
);
    logic        req_valid;
    logic        wr;
    logic        ack;
    logic [31:0] rdata;
    logic [31:0] rdata_next;

    function automatic logic [31:0] pack_pos(input game_pkg::pos_t p);
        return {6'b0, p.x, 6'b0, p.y};
    endfunction

    assign req_valid = bus_req.cyc && bus_req.stb && !ack;
    assign wr        = req_valid && bus_req.we;
    assign start     = wr && (bus_req.adr == bus_pkg::REG_CTRL) && bus_req.dat[0];
    assign bus_rsp   = '{ack: ack, dat: rdata};

    // ------------------------------
    // Readback mux
    always_comb begin
        rdata_next = '0;    // Unmapped reads
        case (bus_req.adr)
            bus_pkg::REG_CMD:     rdata_next = 32'(cmd);
            // Phase 1:0, level 7:4, health 10:8, pending 12
            bus_pkg::REG_STATUS:  rdata_next = {19'b0, cmd != bus_pkg::CMD_NONE, 1'b0,
                                                health, level, 2'b0, phase};
            bus_pkg::REG_SCORE:   rdata_next = {24'b0, score};
            bus_pkg::REG_SHOOTER: rdata_next = pack_pos(shooter_pos);
            bus_pkg::REG_BULLET:  rdata_next = {bullet_live, 31'(pack_pos(bullet_pos))};
            bus_pkg::REG_ALIVE:   rdata_next = 32'(zombie_alive);
            default: begin
                for (int i = 0; i < N_ZOMBIES; i++) begin
                    if (bus_req.adr == 4'(bus_pkg::REG_ZOMBIE0 + i)) begin
                        rdata_next = pack_pos(zombie_pos[i]);
                    end
                end
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
            cmd <= bus_pkg::CMD_NONE;
        end else begin
            ack <= req_valid;   // One wait state
            if (wr && bus_req.adr == bus_pkg::REG_CMD) cmd <= bus_pkg::cmd_e'(bus_req.dat[2:0]);
            else if (cmd_taken) cmd <= bus_pkg::CMD_NONE;
        end
    end

    always_ff @(posedge Clk) begin
        rdata <= rdata_next;
    end

    a_ack_pulse: assert property (@(posedge Clk) disable iff (!rst_n)
        (ack && bus_req.cyc && bus_req.stb) |=> !ack);

endmodule

`default_nettype wire

//--- design/game_core.sv
// Game-logic core top level, wires the tick, phase FSM, actors and host bus slave together
`default_nettype none

module game_core #(
    parameter int FRAME_CYCLES = 1000,
    parameter int N_ZOMBIES    = 3
) (
    input  wire                     Clk,
    input  wire                     rst_n,
    input  wire bus_pkg::wb_req_t   bus_req,
    output bus_pkg::wb_rsp_t        bus_rsp
);
    logic               frame_tick;
    logic               start;
    bus_pkg::cmd_e      cmd;
    logic               cmd_taken;
    game_pkg::pos_t     shooter_pos;
    game_pkg::pos_t     bullet_pos;
    logic               bullet_live;
    logic               bullet_stop;
    logic [N_ZOMBIES-1:0] kill_hit;
    logic [N_ZOMBIES-1:0] contact_hit;
    game_pkg::phase_e   phase;
    logic [3:0]         level;
    logic [2:0]         health;
    logic [7:0]         score;
    logic               new_level;

    // Driven per zombie by the generate loop
    wire game_pkg::pos_t       zombie_pos [N_ZOMBIES];
    wire [N_ZOMBIES-1:0]       zombie_alive;

    frame_timer #(.FRAME_CYCLES(FRAME_CYCLES)) i_frame_timer (
        .Clk, .rst_n, .frame_tick
    );

    game_fsm #(.N_ZOMBIES(N_ZOMBIES)) i_game_fsm (
        .Clk, .rst_n, .frame_tick, .start, .zombie_alive, .kill_hit, .contact_hit,
        .phase, .level, .health, .score, .new_level
    );

    shooter_ctrl i_shooter_ctrl (
        .Clk, .rst_n, .frame_tick, .phase, .cmd, .cmd_taken, .bullet_stop, .new_level,
        .shooter_pos, .bullet_pos, .bullet_live
    );

    // ------------------------------
    // Zombies
    for (genvar i = 0; i < N_ZOMBIES; i++) begin : g_zombie
        zombie_unit #(.ZOMBIE_ID(i)) i_zombie (
            .Clk, .rst_n, .frame_tick, .phase, .new_level, .shooter_pos,
            .killed     (kill_hit[i]),
            .contact    (contact_hit[i]),
            .zombie_pos (zombie_pos[i]),
            .alive      (zombie_alive[i])
        );
    end

    hit_detect #(.N_ZOMBIES(N_ZOMBIES)) i_hit_detect (
        .bullet_pos, .bullet_live, .zombie_pos, .zombie_alive, .shooter_pos,
        .kill_hit, .contact_hit, .bullet_stop
    );

    wb_regs #(.N_ZOMBIES(N_ZOMBIES)) i_wb_regs (
        .Clk, .rst_n, .bus_req, .bus_rsp, .phase, .level, .health, .score,
        .shooter_pos, .bullet_pos, .bullet_live, .zombie_pos, .zombie_alive,
        .cmd_taken, .cmd, .start
    );

endmodule

`default_nettype wire

//--- verification/game_core_tb.sv
// Testbench for the game core that drives the host bus and checks state against a reference model
`default_nettype none

module game_core_tb;

    localparam int PERIOD       = 100;
    localparam int FRAME_CYCLES = 64;
    localparam int N_ZOMBIES    = 3;
    localparam int N_RANDOM     = 40;
    localparam int N_PUSH       = 60;       // Enough per direction to reach each bound
    localparam int N_SHOTS      = 64;
    localparam int N_CMDS       = N_RANDOM + 4 * N_PUSH + N_SHOTS + 2;
    localparam int OVER_TICKS   = 800;      // Longest wait for health to drain
    localparam longint WATCHDOG_TIME = longint'(N_CMDS) * 4 * FRAME_CYCLES * PERIOD
                                     + longint'(OVER_TICKS + 100) * FRAME_CYCLES * PERIOD;

    logic               Clk;
    logic               rst_n;
    bus_pkg::wb_req_t   bus_req;
    bus_pkg::wb_rsp_t   bus_rsp;

    string       name_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    int          n_checks;
    int          n_errors;

    game_core #(.FRAME_CYCLES(FRAME_CYCLES), .N_ZOMBIES(N_ZOMBIES)) i_game_core (
        .Clk, .rst_n, .bus_req, .bus_rsp
    );

    always #(PERIOD / 2) Clk = ~Clk;

    // ------------------------------
    // Bus access and helpers
    task automatic bus_write(input logic [3:0] adr, input logic [31:0] dat);
        @(posedge Clk);
        bus_req <= '{1'b1, 1'b1, 1'b1, adr, dat};
        do @(posedge Clk); while (!bus_rsp.ack);
        bus_req <= '0;
    endtask

    task automatic bus_read(input logic [3:0] adr, output logic [31:0] dat);
        @(posedge Clk);
        bus_req <= '{1'b1, 1'b1, 1'b0, adr, 32'h0};
        do @(posedge Clk); while (!bus_rsp.ack);
        dat = bus_rsp.dat;      // Valid while ack is high
        bus_req <= '0;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    // Clamped shooter position after one command
    function automatic logic [19:0] expected_move(input logic [19:0] p, input bus_pkg::cmd_e c);
        int x;
        int y;
        x = p[19:10];
        y = p[9:0];
        case (c)
            bus_pkg::CMD_MOVE_UP:    y = y - int'(game_pkg::SHOOTER_STEP);
            bus_pkg::CMD_MOVE_DOWN:  y = y + int'(game_pkg::SHOOTER_STEP);
            bus_pkg::CMD_MOVE_LEFT:  x = x - int'(game_pkg::SHOOTER_STEP);
            bus_pkg::CMD_MOVE_RIGHT: x = x + int'(game_pkg::SHOOTER_STEP);
            default: ;
        endcase
        if (x < int'(game_pkg::ARENA_MIN)) x = game_pkg::ARENA_MIN;
        if (x > int'(game_pkg::ARENA_MAX)) x = game_pkg::ARENA_MAX;
        if (y < int'(game_pkg::ARENA_MIN)) y = game_pkg::ARENA_MIN;
        if (y > int'(game_pkg::ARENA_MAX)) y = game_pkg::ARENA_MAX;
        return {10'(x), 10'(y)};
    endfunction

    function automatic int axis_dist(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    function automatic logic in_arena(input logic [9:0] v);
        return v >= game_pkg::ARENA_MIN && v <= game_pkg::ARENA_MAX;
    endfunction

    // Poll STATUS until the command slot empties or the game is over
    task automatic wait_consumed(output logic [31:0] st);
        int n;
        n = 0;
        bus_read(bus_pkg::REG_STATUS, st);
        while (st[12] && st[1:0] != game_pkg::PH_GAME_OVER && n < FRAME_CYCLES) begin
            bus_read(bus_pkg::REG_STATUS, st);
            n++;
        end
        if (st[12] && st[1:0] != game_pkg::PH_GAME_OVER) begin
            n_errors++;
            $display("Command still pending long after a frame tick");
        end
    endtask

    task automatic restart_game();
        bus_write(bus_pkg::REG_CMD, 32'(bus_pkg::CMD_NONE));
        bus_write(bus_pkg::REG_CTRL, 32'h1);
    endtask

    // Compare process
    initial begin
        string       nm;
        logic [31:0] e;
        logic [31:0] a;
        forever begin
            wait (exp_q.size() != 0);
            nm = name_q.pop_front();
            e  = exp_q.pop_front();
            a  = act_q.pop_front();
            n_checks++;
            if (e !== a) begin
                n_errors++;
                $display("Error: %s expected %h actual %h", nm, e, a);
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    // ------------------------------
    // Test sequence
    initial begin
        logic [31:0]   d;
        logic [31:0]   st;
        logic [31:0]   al;
        logic [31:0]   al2;
        logic [31:0]   sc;
        logic [19:0]   sh;
        logic [19:0]   exp_pos;
        int            prev_dx [N_ZOMBIES];
        int            prev_dy [N_ZOMBIES];
        int            dx;
        int            dy;
        int            dead;
        int            n;
        logic [2:0]    prev_health;
        bus_pkg::cmd_e c;

        Clk      = 1'b0;
        n_checks = 0;
        n_errors = 0;
        rst_n   <= 1'b0;
        bus_req <= '0;
        void'($urandom(32'hfe4e_28bf));
        repeat (4) @(posedge Clk);
        rst_n <= 1'b1;

        // Idle after reset
        bus_read(bus_pkg::REG_STATUS, d);
        check_value("idle_status", 32'h0, d);
        bus_read(bus_pkg::REG_SHOOTER, d);
        check_value("idle_shooter", {6'b0, game_pkg::SHOOTER_START.x, 6'b0,
                    game_pkg::SHOOTER_START.y}, d);
        bus_write(bus_pkg::REG_CMD, 32'(bus_pkg::CMD_MOVE_RIGHT));
        repeat (3 * FRAME_CYCLES) @(posedge Clk);
        bus_read(bus_pkg::REG_STATUS, d);
        check_value("idle_pending", 32'h1, 32'(d[12]));
        bus_read(bus_pkg::REG_SHOOTER, d);
        check_value("idle_no_move", 20'(game_pkg::SHOOTER_START), {d[25:16], d[9:0]});
        bus_write(bus_pkg::REG_CMD, 32'(bus_pkg::CMD_NONE));
        // Zombie registers beyond N_ZOMBIES and the spare addresses
        for (int a = int'(bus_pkg::REG_ZOMBIE0) + N_ZOMBIES; a < 16; a++) begin
            bus_read(4'(a), d);
            check_value("unmapped_read", 32'h0, d);
        end

        // Start
        bus_write(bus_pkg::REG_CTRL, 32'h1);
        bus_read(bus_pkg::REG_STATUS, d);
        check_value("start_status", {19'b0, 1'b0, 1'b0, game_pkg::START_HEALTH, 4'd1, 2'b0,
                    game_pkg::PH_PLAY}, d);
        bus_read(bus_pkg::REG_SCORE, d);
        check_value("start_score", 32'h0, d);
        bus_read(bus_pkg::REG_ALIVE, d);
        check_value("start_alive", 32'((1 << N_ZOMBIES) - 1), d);
        for (int z = 0; z < N_ZOMBIES; z++) begin
            bus_read(4'(bus_pkg::REG_ZOMBIE0 + z), d);
            check_value("spawn_pos", 20'(game_pkg::SPAWN_POS[z]), {d[25:16], d[9:0]});
        end

        // Chasing a still shooter
        sh = game_pkg::SHOOTER_START;
        for (int s = 0; s < 40; s++) begin
            for (int z = 0; z < N_ZOMBIES; z++) begin
                bus_read(4'(bus_pkg::REG_ZOMBIE0 + z), d);
                dx = axis_dist(d[25:16], sh[19:10]);
                dy = axis_dist(d[9:0], sh[9:0]);
                check_value("zombie_in_arena", 32'h1, 32'(in_arena(d[25:16]) && in_arena(d[9:0])));
                if (s > 0) begin
                    check_value("chase_dx", 32'h1, 32'(dx <= prev_dx[z]));
                    check_value("chase_dy", 32'h1, 32'(dy <= prev_dy[z]));
                end
                prev_dx[z] = dx;
                prev_dy[z] = dy;
            end
            repeat (32) @(posedge Clk);
        end

        // Movement with random commands and then pushes against each bound
        exp_pos = game_pkg::SHOOTER_START;     // No command taken since the start
        for (int i = 0; i < N_RANDOM + 4 * N_PUSH; i++) begin
            if (i < N_RANDOM) c = bus_pkg::cmd_e'($urandom_range(4, 1));
            else c = bus_pkg::cmd_e'(3'(1 + (i - N_RANDOM) / N_PUSH));
            bus_write(bus_pkg::REG_CMD, 32'(c));
            wait_consumed(st);
            if (st[1:0] == game_pkg::PH_GAME_OVER) begin
                restart_game();     // Shooter goes back to start
                exp_pos = game_pkg::SHOOTER_START;
            end else begin
                exp_pos = expected_move(exp_pos, c);
                bus_read(bus_pkg::REG_SHOOTER, d);
                check_value("shooter_move", 32'(exp_pos), 32'({d[25:16], d[9:0]}));
            end
        end

        // ------------------------------
        // Scoring and levels
        for (int i = 0; i < N_SHOTS; i++) begin
            c = (i % 2 == 1) ? bus_pkg::CMD_FIRE : bus_pkg::cmd_e'(3'(1 + (i / 2) % 4));
            bus_write(bus_pkg::REG_CMD, 32'(c));
            wait_consumed(st);
            do begin    // Retry if a kill lands between the reads
                bus_read(bus_pkg::REG_ALIVE, al);
                bus_read(bus_pkg::REG_SCORE, sc);
                bus_read(bus_pkg::REG_STATUS, st);
                bus_read(bus_pkg::REG_ALIVE, al2);
            end while (al != al2);
            dead = N_ZOMBIES - $countones(al[N_ZOMBIES-1:0]);
            check_value("score_rule", 32'(N_ZOMBIES * (int'(st[7:4]) - 1) + dead), sc);
            bus_read(bus_pkg::REG_BULLET, d);
            if (d[31]) begin
                check_value("bullet_in_arena", 32'h1, 32'(in_arena(d[25:16]) && in_arena(d[9:0])));
            end
            if (st[1:0] == game_pkg::PH_GAME_OVER) restart_game();
        end

        // Game over by contact
        bus_read(bus_pkg::REG_STATUS, st);
        if (st[1:0] == game_pkg::PH_GAME_OVER) restart_game();
        bus_read(bus_pkg::REG_STATUS, st);
        prev_health = st[10:8];
        n = 0;
        while (st[1:0] != game_pkg::PH_GAME_OVER && n < OVER_TICKS * FRAME_CYCLES / 3) begin
            bus_read(bus_pkg::REG_STATUS, st);
            if (st[10:8] != prev_health) check_value("health_step", 32'(prev_health - 3'd1),
                                                     32'(st[10:8]));
            prev_health = st[10:8];
            n++;
        end
        if (st[1:0] != game_pkg::PH_GAME_OVER) begin
            n_errors++;
            $display("Game never reached game over while the shooter stood still");
        end
        check_value("over_health", 32'h0, 32'(st[10:8]));
        bus_read(bus_pkg::REG_SCORE, sc);
        bus_read(bus_pkg::REG_SHOOTER, d);
        bus_write(bus_pkg::REG_CMD, 32'(bus_pkg::CMD_MOVE_LEFT));
        repeat (3 * FRAME_CYCLES) @(posedge Clk);
        bus_read(bus_pkg::REG_SCORE, al);
        check_value("over_score_frozen", sc, al);
        bus_read(bus_pkg::REG_SHOOTER, al);
        check_value("over_shooter_frozen", d, al);
        restart_game();
        bus_read(bus_pkg::REG_STATUS, d);
        check_value("restart_status", {19'b0, 1'b0, 1'b0, game_pkg::START_HEALTH, 4'd1, 2'b0,
                    game_pkg::PH_PLAY}, d);
        bus_read(bus_pkg::REG_SCORE, d);
        check_value("restart_score", 32'h0, d);

        wait (exp_q.size() == 0);
        @(posedge Clk);
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
design/game_pkg.sv
design/bus_pkg.sv
design/frame_timer.sv
design/game_fsm.sv
design/shooter_ctrl.sv
design/zombie_unit.sv
design/hit_detect.sv
design/wb_regs.sv
design/game_core.sv
verification/game_core_tb.sv

//--- Bender.yml
package:
  name: game_core

sources:
  - design/game_pkg.sv
  - design/bus_pkg.sv
  - design/frame_timer.sv
  - design/game_fsm.sv
  - design/shooter_ctrl.sv
  - design/zombie_unit.sv
  - design/hit_detect.sv
  - design/wb_regs.sv
  - design/game_core.sv
  - target: test
    files:
      - verification/game_core_tb.sv
